//--- src.f
design/core_types_pkg.sv
design/rob_pkg.sv
design/retire_stage.sv
design/rob.sv
design/free_list.sv
design/map_tables.sv
design/rename_retire_top.sv
sim/rename_retire_chk.sv
sim/rename_retire_tb.sv

//--- Makefile
TOP = rename_retire_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f src.f -o $(TOP)
	./obj_dir/$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "RESULT: FAIL" sim.log; then exit 1; fi
	@grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

//--- sim/rename_retire_tb.sv
`timescale 1ns/10ps

module rename_retire_tb
    import core_types_pkg::*;
    import rob_pkg::*;
();

    localparam int PERIOD   = 40;
    localparam int N_CYCLES = 2000;

    typedef struct packed {
        lane_mask_t               retire_en;
        lane_mask_t               sq_retire_en;
        preg_t [RETIRE_WIDTH-1:0] retire_told;
        logic                     recover_en;
        xlen_t                    target_pc;
        logic                     halt;
        preg_t                    alloc_tnew;
        preg_t                    dispatch_told;
        logic                     rob_full;
        rob_ptr_t                 dispatch_idx;
    } expect_t;

    logic                     clk;
    logic                     rst_n;
    logic                     dispatch_en;
    dispatch_t                dispatch_in;
    logic                     complete_en;
    rob_ptr_t                 complete_idx;
    lane_mask_t               sq_stall;
    logic                     rob_full;
    rob_ptr_t                 dispatch_idx;
    preg_t                    alloc_tnew;
    preg_t                    dispatch_told;
    lane_mask_t               retire_en;
    lane_mask_t               sq_retire_en;
    preg_t [RETIRE_WIDTH-1:0] retire_told;
    logic                     recover_en;
    xlen_t                    target_pc;
    logic                     halt;

    // reference state: ROB ring, free list ring and both register maps
    rob_entry_t  m_rob [ROB_SIZE];
    rob_ptr_t    m_head;
    rob_ptr_t    m_tail;
    int          m_count;
    logic        m_halted;
    preg_t       m_ring [ROB_SIZE];
    rob_ptr_t    m_fl_head;
    rob_ptr_t    m_fl_tail;
    int          m_dist;
    maptable_t   m_spec;
    maptable_t   m_arch;
    logic [31:0] lcg_state;
    int          errors;
    int          checks;

    rename_retire_top u_rename_retire_top (
        .clk           (clk),
        .rst_n         (rst_n),
        .dispatch_en   (dispatch_en),
        .dispatch_in   (dispatch_in),
        .complete_en   (complete_en),
        .complete_idx  (complete_idx),
        .sq_stall      (sq_stall),
        .rob_full      (rob_full),
        .dispatch_idx  (dispatch_idx),
        .alloc_tnew    (alloc_tnew),
        .dispatch_told (dispatch_told),
        .retire_en     (retire_en),
        .sq_retire_en  (sq_retire_en),
        .retire_told   (retire_told),
        .recover_en    (recover_en),
        .target_pc     (target_pc),
        .halt          (halt)
    );

    always #(PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        // the low bits of this generator repeat quickly, so they are dropped
        return {8'h00, lcg_state[31:8]};
    endfunction

    function automatic void reset_model();
        for (int i = 0; i < ROB_SIZE; i++) begin
            m_rob[i]  = '0;
            m_ring[i] = preg_t'(NUM_AREG + i);
        end
        for (int i = 0; i < NUM_AREG; i++) begin
            m_spec[i] = preg_t'(i);
            m_arch[i] = preg_t'(i);
        end
        m_head    = '0;
        m_tail    = '0;
        m_count   = 0;
        m_halted  = 1'b0;
        m_fl_head = '0;
        m_fl_tail = '0;
        m_dist    = 0;
    endfunction

    // predicts one clock cycle and moves the reference state across the edge
    function automatic expect_t model_cycle(input logic den, input dispatch_t din,
                                            input logic cen, input rob_ptr_t cidx,
                                            input lane_mask_t stall);
        expect_t    e;
        rob_entry_t ent;
        rob_ptr_t   slot;
        maptable_t  rec_map;
        preg_t      freed [$];
        int         n_ret;
        int         lane;
        logic       stop;
        logic       alloc;
        logic       do_complete;
        e              = '0;
        e.rob_full     = m_count == ROB_SIZE;
        e.dispatch_idx = m_tail;
        rec_map        = m_arch;
        n_ret          = 0;
        stop           = m_halted;
        alloc          = den && din.arch_reg != '0;
        do_complete    = cen && m_rob[cidx].valid;
        for (int k = 0; k < RETIRE_WIDTH; k++) begin
            slot = m_head + rob_ptr_t'(k);
            ent  = m_rob[slot];
            lane = RETIRE_WIDTH - 1 - k;
            if (stop || !ent.completed || (ent.arch_reg != '0 && stall[lane])) begin
                stop = 1'b1;
            end else begin
                e.sq_retire_en[lane] = ent.is_store;
                if (ent.arch_reg != '0) begin
                    e.retire_en[lane]     = 1'b1;
                    e.retire_told[lane]   = ent.told;
                    rec_map[ent.arch_reg] = ent.tnew;
                    freed.push_back(ent.told);
                end
                m_rob[slot]  = '0;
                n_ret        = n_ret + 1;
                e.recover_en = ent.precise_state_need;
                e.target_pc  = ent.precise_state_need ? ent.target_pc : '0;
                e.halt       = !ent.precise_state_need && ent.halt;
                stop         = ent.precise_state_need || ent.halt;
            end
        end
        e.alloc_tnew    = alloc ? m_ring[m_fl_head] : '0;
        e.dispatch_told = alloc ? m_spec[din.arch_reg] : '0;
        foreach (freed[j]) begin
            m_ring[m_fl_tail] = freed[j];
            m_fl_tail         = m_fl_tail + rob_ptr_t'(1);
        end
        m_arch = rec_map;
        m_head = m_head + rob_ptr_t'(n_ret);
        if (e.recover_en) begin
            for (int i = 0; i < ROB_SIZE; i++) begin
                m_rob[i] = '0;
            end
            m_tail    = m_head;
            m_count   = 0;
            m_fl_head = m_fl_head - rob_ptr_t'(m_dist - freed.size());
            m_dist    = 0;
            m_spec    = rec_map;
        end else begin
            if (den) begin
                m_rob[m_tail] = '{valid: 1'b1, completed: 1'b0, arch_reg: din.arch_reg,
                                  tnew: e.alloc_tnew, told: e.dispatch_told,
                                  is_store: din.is_store, halt: din.halt,
                                  precise_state_need: din.precise_state_need,
                                  target_pc: din.target_pc};
                m_tail = m_tail + rob_ptr_t'(1);
            end
            if (do_complete) begin
                m_rob[cidx].completed = 1'b1;
            end
            if (alloc) begin
                m_spec[din.arch_reg] = e.alloc_tnew;
                m_fl_head            = m_fl_head + rob_ptr_t'(1);
            end
            m_count  = m_count + int'(den) - n_ret;
            m_dist   = m_dist + int'(alloc) - freed.size();
            m_halted = m_halted || e.halt;
        end
        return e;
    endfunction

    function automatic void check_field(input string name, input logic [31:0] got,
                                        input logic [31:0] want);
        checks = checks + 1;
        assert (got === want) else begin
            errors = errors + 1;
            $display("MISMATCH at %0t: %s is %0h, expected %0h", $time, name, got, want);
        end
    endfunction

    task automatic drive_inputs(input logic halt_ok);
        logic [31:0] r;
        int          off;
        rob_ptr_t    slot;
        r                              = lcg_next();
        dispatch_en                    = !rob_full && r[1:0] != 2'b00;
        dispatch_in.arch_reg           = (r[4:2] == 3'b000) ? '0 : r[9:5];
        dispatch_in.is_store           = r[11:10] == 2'b00;
        dispatch_in.precise_state_need = r[15:12] == 4'h0;
        dispatch_in.halt               = halt_ok && r[19:16] == 4'h0;
        dispatch_in.target_pc          = lcg_next();
        r                              = lcg_next();
        sq_stall     = {r[1:0] == 2'b00, r[3:2] == 2'b00, r[5:4] == 2'b00};
        complete_en  = 1'b0;
        complete_idx = '0;
        off          = int'(r[11:8]);
        // complete one waiting entry, picked at random, so completion runs out of order
        if (m_count > 0) begin
            for (int k = 0; k < ROB_SIZE; k++) begin
                slot = m_head + rob_ptr_t'((off + k) % m_count);
                if (!complete_en && m_rob[slot].valid && !m_rob[slot].completed) begin
                    complete_en  = 1'b1;
                    complete_idx = slot;
                end
            end
        end
    endtask

    always @(posedge clk) begin
        expect_t want;
        expect_t got;
        if (!rst_n) begin
            reset_model();
        end else begin
            want = model_cycle(dispatch_en, dispatch_in, complete_en, complete_idx, sq_stall);
            got  = '{retire_en, sq_retire_en, retire_told, recover_en, target_pc, halt,
                     alloc_tnew, dispatch_told, rob_full, dispatch_idx};
            // an old mapping only leaves on a lane that retires a writer
            for (int i = 0; i < RETIRE_WIDTH; i++) begin
                if (!want.retire_en[i]) begin
                    got.retire_told[i] = '0;
                end
            end
            check_field("retire_en", 32'(got.retire_en), 32'(want.retire_en));
            check_field("sq_retire_en", 32'(got.sq_retire_en), 32'(want.sq_retire_en));
            check_field("retire_told", 32'(got.retire_told), 32'(want.retire_told));
            check_field("recover_en", 32'(got.recover_en), 32'(want.recover_en));
            check_field("target_pc", got.target_pc, want.target_pc);
            check_field("halt", 32'(got.halt), 32'(want.halt));
            check_field("alloc_tnew", 32'(got.alloc_tnew), 32'(want.alloc_tnew));
            check_field("dispatch_told", 32'(got.dispatch_told), 32'(want.dispatch_told));
            check_field("rob_full", 32'(got.rob_full), 32'(want.rob_full));
            check_field("dispatch_idx", 32'(got.dispatch_idx), 32'(want.dispatch_idx));
        end
    end

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        dispatch_en  = 1'b0;
        dispatch_in  = '0;
        complete_en  = 1'b0;
        complete_idx = '0;
        sq_stall     = '0;
        lcg_state    = 32'h37fb;
        errors       = 0;
        checks       = 0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        // halt entries only show up in the last quarter, since nothing retires after one
        for (int c = 0; c < N_CYCLES; c++) begin
            drive_inputs(c >= N_CYCLES * 3 / 4);
            @(negedge clk);
        end
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(PERIOD * (N_CYCLES + 5 + 50));
        $display("timeout: the run did not reach its end in the expected time");
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

//--- sim/rename_retire_chk.sv
`timescale 1ns/10ps

module rename_retire_chk
    import rob_pkg::*;
(
    input logic       clk,
    input logic       rst_n,
    input lane_mask_t retire_valid,
    input logic       recover_en,
    input logic       halt,
    input logic       dispatch_en,
    input logic       rob_full
);

    // a lane only retires behind an older lane that retired too
    a_retire_contiguous: assert property (@(posedge clk) disable iff (!rst_n)
        retire_valid inside {3'b000, 3'b100, 3'b110, 3'b111})
        else $error("retire_valid %b has a gap below lane 2", retire_valid);

    a_recover_not_halt: assert property (@(posedge clk) disable iff (!rst_n)
        !(recover_en && halt))
        else $error("recover_en and halt are raised in the same cycle");

    a_no_dispatch_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        !(dispatch_en && rob_full))
        else $error("dispatch_en is raised while the ROB is full");

endmodule

bind rename_retire_top rename_retire_chk u_rename_retire_chk (
    .clk          (clk),
    .rst_n        (rst_n),
    .retire_valid (retire_valid),
    .recover_en   (recover_en),
    .halt         (halt),
    .dispatch_en  (dispatch_en),
    .rob_full     (rob_full)
);

//--- design/rename_retire_top.sv
`timescale 1ns/10ps

module rename_retire_top
    import core_types_pkg::*;
    import rob_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     dispatch_en,
    input  dispatch_t                dispatch_in,
    input  logic                     complete_en,
    input  rob_ptr_t                 complete_idx,
    input  lane_mask_t               sq_stall,
    output logic                     rob_full,
    output rob_ptr_t                 dispatch_idx,
    output preg_t                    alloc_tnew,
    output preg_t                    dispatch_told,
    output lane_mask_t               retire_en,
    output lane_mask_t               sq_retire_en,
    output preg_t [RETIRE_WIDTH-1:0] retire_told,
    output logic                     recover_en,
    output xlen_t                    target_pc,
    output logic                     halt
);

    logic                          alloc_en;
    preg_t                         alloc_preg;
    preg_t                         rename_told;
    rob_entry_t                    dispatch_entry;
    rob_entry_t [RETIRE_WIDTH-1:0] head_entries;
    lane_mask_t                    retire_valid;
    arch_reg_t [RETIRE_WIDTH-1:0]  retire_arch_reg;
    preg_t [RETIRE_WIDTH-1:0]      retire_tnew;
    rob_ptr_t                      fl_head;
    rob_ptr_t                      recover_head;
    rob_cnt_t                      fl_distance;
    maptable_t                     arch_maptable;
    maptable_t                     recover_maptable;

    // register 0 is hardwired to zero and never takes a physical register
    assign alloc_en      = dispatch_en && (dispatch_in.arch_reg != '0);
    assign alloc_tnew    = alloc_en ? alloc_preg : '0;
    assign dispatch_told = alloc_en ? rename_told : '0;

    assign dispatch_entry = '{
        valid:              1'b1,
        completed:          1'b0,
        arch_reg:           dispatch_in.arch_reg,
        tnew:               alloc_tnew,
        told:               dispatch_told,
        is_store:           dispatch_in.is_store,
        halt:               dispatch_in.halt,
        precise_state_need: dispatch_in.precise_state_need,
        target_pc:          dispatch_in.target_pc
    };

    rob u_rob (
        .clk            (clk),
        .rst_n          (rst_n),
        .dispatch_en    (dispatch_en),
        .dispatch_entry (dispatch_entry),
        .complete_en    (complete_en),
        .complete_idx   (complete_idx),
        .retire_valid   (retire_valid),
        .recover_en     (recover_en),
        .halt           (halt),
        .head_entries   (head_entries),
        .dispatch_idx   (dispatch_idx),
        .rob_full       (rob_full)
    );

    retire_stage u_retire_stage (
        .head_entries     (head_entries),
        .fl_distance      (fl_distance),
        .fl_head          (fl_head),
        .arch_maptable    (arch_maptable),
        .sq_stall         (sq_stall),
        .retire_valid     (retire_valid),
        .retire_en        (retire_en),
        .sq_retire_en     (sq_retire_en),
        .retire_arch_reg  (retire_arch_reg),
        .retire_tnew      (retire_tnew),
        .retire_told      (retire_told),
        .recover_en       (recover_en),
        .target_pc        (target_pc),
        .recover_head     (recover_head),
        .recover_maptable (recover_maptable),
        .halt             (halt)
    );

    free_list u_free_list (
        .clk          (clk),
        .rst_n        (rst_n),
        .alloc_en     (alloc_en),
        .retire_en    (retire_en),
        .retire_told  (retire_told),
        .recover_en   (recover_en),
        .recover_head (recover_head),
        .alloc_preg   (alloc_preg),
        .fl_head      (fl_head),
        .fl_distance  (fl_distance)
    );

    map_tables u_map_tables (
        .clk              (clk),
        .rst_n            (rst_n),
        .rename_en        (alloc_en),
        .rename_arch_reg  (dispatch_in.arch_reg),
        .rename_preg      (alloc_preg),
        .retire_en        (retire_en),
        .retire_arch_reg  (retire_arch_reg),
        .retire_tnew      (retire_tnew),
        .recover_en       (recover_en),
        .recover_maptable (recover_maptable),
        .rename_told      (rename_told),
        .arch_maptable    (arch_maptable)
    );

endmodule

//--- design/map_tables.sv
`timescale 1ns/10ps

module map_tables
    import core_types_pkg::*;
    import rob_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         rename_en,
    input  arch_reg_t                    rename_arch_reg,
    input  preg_t                        rename_preg,
    input  lane_mask_t                   retire_en,
    input  arch_reg_t [RETIRE_WIDTH-1:0] retire_arch_reg,
    input  preg_t [RETIRE_WIDTH-1:0]     retire_tnew,
    input  logic                         recover_en,
    input  maptable_t                    recover_maptable,
    output preg_t                        rename_told,
    output maptable_t                    arch_maptable
);

    maptable_t spec_map;
    maptable_t arch_map;

    assign rename_told   = spec_map[rename_arch_reg];
    assign arch_maptable = arch_map;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_AREG; i++) begin
                spec_map[i] <= preg_t'(i);
            end
        end else if (recover_en) begin
            spec_map <= recover_maptable;
        end else if (rename_en) begin
            spec_map[rename_arch_reg] <= rename_preg;
        end
    end

    // lanes go oldest first so a younger write to the same register wins
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_AREG; i++) begin
                arch_map[i] <= preg_t'(i);
            end
        end else begin
            for (int i = RETIRE_WIDTH - 1; i >= 0; i--) begin
                if (retire_en[i]) begin
                    arch_map[retire_arch_reg[i]] <= retire_tnew[i];
                end
            end
        end
    end

endmodule

//--- design/free_list.sv
`timescale 1ns/10ps

module free_list
    import core_types_pkg::*;
    import rob_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     alloc_en,
    input  lane_mask_t               retire_en,
    input  preg_t [RETIRE_WIDTH-1:0] retire_told,
    input  logic                     recover_en,
    input  rob_ptr_t                 recover_head,
    output preg_t                    alloc_preg,
    output rob_ptr_t                 fl_head,
    output rob_cnt_t                 fl_distance
);

    preg_t                       ring [ROB_SIZE];
    rob_ptr_t                    head;
    rob_ptr_t                    tail;
    rob_cnt_t                    distance;
    rob_cnt_t                    free_cnt;
    rob_ptr_t [RETIRE_WIDTH-1:0] wr_slot;

    // old mappings are packed at the tail in program order, oldest lane first
    always_comb begin
        free_cnt = '0;
        for (int i = RETIRE_WIDTH - 1; i >= 0; i--) begin
            wr_slot[i] = tail + rob_ptr_t'(free_cnt);
            free_cnt   = free_cnt + rob_cnt_t'(retire_en[i]);
        end
    end

    assign alloc_preg  = ring[head];
    assign fl_head     = head;
    assign fl_distance = distance;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            head     <= '0;
            tail     <= '0;
            distance <= '0;
            for (int i = 0; i < ROB_SIZE; i++) begin
                ring[i] <= preg_t'(NUM_PREG - ROB_SIZE + i);
            end
        end else begin
            for (int i = 0; i < RETIRE_WIDTH; i++) begin
                if (retire_en[i]) begin
                    ring[wr_slot[i]] <= retire_told[i];
                end
            end
            tail <= tail + rob_ptr_t'(free_cnt);
            if (recover_en) begin
                // slots between the rewound head and the old head still hold
                // the squashed registers, so moving the head frees them
                head     <= recover_head;
                distance <= '0;
            end else begin
                head     <= head + rob_ptr_t'(alloc_en);
                distance <= distance + rob_cnt_t'(alloc_en) - free_cnt;
            end
        end
    end

endmodule

//--- design/rob.sv
`timescale 1ns/10ps

module rob
    import core_types_pkg::*;
    import rob_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          dispatch_en,
    input  rob_entry_t                    dispatch_entry,
    input  logic                          complete_en,
    input  rob_ptr_t                      complete_idx,
    input  lane_mask_t                    retire_valid,
    input  logic                          recover_en,
    input  logic                          halt,
    output rob_entry_t [RETIRE_WIDTH-1:0] head_entries,
    output rob_ptr_t                      dispatch_idx,
    output logic                          rob_full
);

    rob_entry_t                  entries [ROB_SIZE];
    rob_ptr_t                    head;
    rob_ptr_t                    tail;
    rob_cnt_t                    count;
    rob_cnt_t                    retire_cnt;
    rob_ptr_t                    next_head;
    rob_ptr_t [RETIRE_WIDTH-1:0] lane_idx;
    logic                        halted;

    assign retire_cnt   = rob_cnt_t'($countones(retire_valid));
    assign next_head    = head + rob_ptr_t'(retire_cnt);
    assign dispatch_idx = tail;
    assign rob_full     = count == rob_cnt_t'(ROB_SIZE);

    // lane 2 reads the head, lower lanes the entries behind it
    always_comb begin
        for (int i = 0; i < RETIRE_WIDTH; i++) begin
            lane_idx[i] = head + rob_ptr_t'(RETIRE_WIDTH - 1 - i);
            if (!halted && entries[lane_idx[i]].valid) begin
                head_entries[i] = entries[lane_idx[i]];
            end else begin
                head_entries[i] = '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            head   <= '0;
            tail   <= '0;
            count  <= '0;
            halted <= 1'b0;
            for (int i = 0; i < ROB_SIZE; i++) begin
                entries[i] <= '0;
            end
        end else if (recover_en) begin
            // the recovering entry retires and every younger one is squashed
            for (int i = 0; i < ROB_SIZE; i++) begin
                entries[i] <= '0;
            end
            head  <= next_head;
            tail  <= next_head;
            count <= '0;
        end else begin
            for (int i = 0; i < RETIRE_WIDTH; i++) begin
                if (retire_valid[i]) begin
                    entries[lane_idx[i]] <= '0;
                end
            end
            if (dispatch_en) begin
                entries[tail] <= dispatch_entry;
                tail          <= tail + rob_ptr_t'(1);
            end
            if (complete_en && entries[complete_idx].valid) begin
                entries[complete_idx].completed <= 1'b1;
            end
            head  <= next_head;
            count <= count + rob_cnt_t'(dispatch_en) - retire_cnt;
            if (halt) begin
                halted <= 1'b1;
            end
        end
    end

endmodule

//--- design/retire_stage.sv
`timescale 1ns/10ps

module retire_stage
    import core_types_pkg::*;
    import rob_pkg::*;
(
    input  rob_entry_t [RETIRE_WIDTH-1:0] head_entries,
    input  rob_cnt_t                      fl_distance,
    input  rob_ptr_t                      fl_head,
    input  maptable_t                     arch_maptable,
    input  lane_mask_t                    sq_stall,
    output lane_mask_t                    retire_valid,
    output lane_mask_t                    retire_en,
    output lane_mask_t                    sq_retire_en,
    output arch_reg_t [RETIRE_WIDTH-1:0]  retire_arch_reg,
    output preg_t [RETIRE_WIDTH-1:0]      retire_tnew,
    output preg_t [RETIRE_WIDTH-1:0]      retire_told,
    output logic                          recover_en,
    output xlen_t                         target_pc,
    output rob_ptr_t                      recover_head,
    output maptable_t                     recover_maptable,
    output logic                          halt
);

    lane_mask_t writes;
    lane_mask_t ready;
    rob_cnt_t   rewind;

    always_comb begin
        for (int i = 0; i < RETIRE_WIDTH; i++) begin
            writes[i]          = head_entries[i].arch_reg != '0;
            // a writing entry waits while the store queue holds its lane
            ready[i]           = head_entries[i].completed && !(writes[i] && sq_stall[i]);
            retire_arch_reg[i] = head_entries[i].arch_reg;
            retire_tnew[i]     = head_entries[i].tnew;
            retire_told[i]     = head_entries[i].told;
        end
    end

    always_comb begin : retire_chain
        logic go;
        retire_valid     = '0;
        retire_en        = '0;
        sq_retire_en     = '0;
        recover_en       = 1'b0;
        target_pc        = '0;
        halt             = 1'b0;
        recover_maptable = arch_maptable;
        rewind           = fl_distance;
        go               = 1'b1;
        // walk from the oldest lane and stop at the first one that cannot leave
        for (int i = RETIRE_WIDTH - 1; i >= 0; i--) begin
            if (go && ready[i]) begin
                retire_valid[i] = 1'b1;
                retire_en[i]    = writes[i];
                sq_retire_en[i] = head_entries[i].is_store;
                if (writes[i]) begin
                    recover_maptable[head_entries[i].arch_reg] = head_entries[i].tnew;
                    rewind = rewind - rob_cnt_t'(1);
                end
                if (head_entries[i].precise_state_need) begin
                    recover_en = 1'b1;
                    target_pc  = head_entries[i].target_pc;
                end else begin
                    halt = head_entries[i].halt;
                end
                go = !head_entries[i].precise_state_need && !head_entries[i].halt;
            end else begin
                go = 1'b0;
            end
        end
    end

    // rewind is what stays allocated to younger writers once this cycle retires,
    // and those registers are all squashed by the recovery
    assign recover_head = fl_head - rob_ptr_t'(rewind);

endmodule

//--- design/rob_pkg.sv
package rob_pkg;

    import core_types_pkg::*;

    localparam int RETIRE_WIDTH = 3;

    // one bit per retire lane, lane 2 being the oldest
    typedef logic [RETIRE_WIDTH-1:0] lane_mask_t;

    typedef struct packed {
        logic      valid;
        logic      completed;
        arch_reg_t arch_reg;
        preg_t     tnew;
        preg_t     told;
        logic      is_store;
        logic      halt;
        logic      precise_state_need;
        xlen_t     target_pc;
    } rob_entry_t;

    typedef struct packed {
        arch_reg_t arch_reg;
        logic      is_store;
        logic      halt;
        logic      precise_state_need;
        xlen_t     target_pc;
    } dispatch_t;

endpackage

//--- design/core_types_pkg.sv
package core_types_pkg;

    localparam int XLEN     = 32;
    localparam int NUM_AREG = 32;
    localparam int ROB_SIZE = 16;
    // each in-flight writer holds one register beyond the architectural set
    localparam int NUM_PREG = NUM_AREG + ROB_SIZE;

    localparam int AREG_W    = $clog2(NUM_AREG);
    localparam int PREG_W    = $clog2(NUM_PREG);
    localparam int ROB_PTR_W = $clog2(ROB_SIZE);
    localparam int ROB_CNT_W = $clog2(ROB_SIZE + 1);

    typedef logic [XLEN-1:0]      xlen_t;
    typedef logic [AREG_W-1:0]    arch_reg_t;
    typedef logic [PREG_W-1:0]    preg_t;
    typedef logic [ROB_PTR_W-1:0] rob_ptr_t;
    typedef logic [ROB_CNT_W-1:0] rob_cnt_t;

    // one physical register number per architectural register
    typedef preg_t [NUM_AREG-1:0] maptable_t;

endpackage
